// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_memory
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dcache.sv ====
`timescale 1ns/1ps

module dcache (
	input  logic               clk,
	input  logic               rst_n,
	input  mem_pkg::mem_cmd_t  cmd,
	output mem_pkg::mem_rsp_t  rsp,
	output mem_pkg::host_req_t host_req,
	input  mem_pkg::host_rsp_t host_rsp
);

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_writeback,
		st_fill,
		st_respond
	} state_t;

	// line viewed as an array of words
	typedef logic [mem_pkg::words_per_line-1:0][mem_pkg::word_bits-1:0] line_t;

	state_t state;

	// direct mapped storage
	line_t data_mem [mem_pkg::num_lines];
	logic [mem_pkg::tag_bits-1:0] tag_mem [mem_pkg::num_lines];
	logic [mem_pkg::num_lines-1:0] valid_bits;
	logic [mem_pkg::num_lines-1:0] dirty_bits;

	// access held across a miss
	mem_pkg::mem_cmd_t req;
	// incoming command when idle, held one otherwise
	mem_pkg::mem_cmd_t cur;

	logic [mem_pkg::index_bits-1:0] cur_idx;
	logic [mem_pkg::tag_bits-1:0] cur_tag;
	logic [mem_pkg::word_sel_bits-1:0] cur_word;
	logic hit;
	logic victim_dirty;
	logic do_access;
	logic fill_done;
	mem_pkg::word_t victim_addr;
	mem_pkg::word_t line_addr;

	// host request registers
	mem_pkg::host_op_t host_op;
	mem_pkg::word_t host_addr;
	logic [mem_pkg::line_bits-1:0] host_data;

	// response registers
	logic rsp_valid;
	logic rsp_load;
	mem_pkg::word_t rsp_rdata;

	assign cur = (state == st_idle) ? cmd : req;

	// addr split: tag | index | word | byte
	assign cur_idx = cur.addr[mem_pkg::offset_bits +: mem_pkg::index_bits];
	assign cur_tag = cur.addr[mem_pkg::word_bits-1 -: mem_pkg::tag_bits];
	assign cur_word = cur.addr[mem_pkg::offset_bits-1:2];

	assign hit = valid_bits[cur_idx] && (tag_mem[cur_idx] == cur_tag);
	assign victim_dirty = valid_bits[cur_idx] && dirty_bits[cur_idx];
	// victim goes back to its own line
	assign victim_addr = {tag_mem[cur_idx], cur_idx, {mem_pkg::offset_bits{1'b0}}};
	assign line_addr = {cur_tag, cur_idx, {mem_pkg::offset_bits{1'b0}}};

	// hit on arrival, or replay once the line is in
	assign do_access = (state == st_idle && cur.valid && hit) || state == st_respond;
	assign fill_done = state == st_fill && host_rsp.rd_valid;

	assign rsp = '{valid: rsp_valid, rdata: rsp_rdata, start: 1'b0, load: rsp_load};
	assign host_req = '{op: host_op, addr: host_addr, data: host_data};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
			valid_bits <= '0;
			dirty_bits <= '0;
			rsp_valid <= 1'b0;
			host_op <= mem_pkg::host_idle;
		end else begin
			rsp_valid <= do_access;
			// store hit marks the line dirty
			if (do_access && cur.wr)
				dirty_bits[cur_idx] <= 1'b1;
			case (state)
				st_idle: begin
					if (cur.valid && !hit)
						state <= st_lookup;
				end
				st_lookup: begin
					// write allocate, evict first if dirty
					if (victim_dirty) begin
						host_op <= mem_pkg::host_write;
						state <= st_writeback;
					end else begin
						host_op <= mem_pkg::host_read;
						state <= st_fill;
					end
				end
				st_writeback: begin
					if (host_rsp.tx_done) begin
						host_op <= mem_pkg::host_read;
						state <= st_fill;
					end
				end
				st_fill: begin
					// clean copy after the fill
					if (host_rsp.rd_valid) begin
						host_op <= mem_pkg::host_idle;
						valid_bits[cur_idx] <= 1'b1;
						dirty_bits[cur_idx] <= 1'b0;
						state <= st_respond;
					end
				end
				st_respond: begin
					state <= st_idle;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && cur.valid)
			req <= cmd;
		// fill and word write never in the same cycle
		if (fill_done) begin
			data_mem[cur_idx] <= host_rsp.data;
			tag_mem[cur_idx] <= cur_tag;
		end else if (do_access && cur.wr) begin
			data_mem[cur_idx][cur_word] <= cur.wdata;
		end
		if (do_access) begin
			rsp_rdata <= data_mem[cur_idx][cur_word];
			rsp_load <= !cur.wr;
		end
		// set up the host transfer on leaving lookup
		if (state == st_lookup) begin
			host_addr <= victim_dirty ? victim_addr : line_addr;
			host_data <= data_mem[cur_idx];
		end else if (state == st_writeback && host_rsp.tx_done) begin
			host_addr <= line_addr;
		end
	end

	a_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
		host_req.op inside {mem_pkg::host_idle, mem_pkg::host_read, mem_pkg::host_write});

	// controller sees a steady request until it answers
	a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		(host_req.op != mem_pkg::host_idle && !host_rsp.tx_done && !host_rsp.rd_valid)
		|=> $stable(host_req));

endmodule

// ==== mem_decode.sv ====
`timescale 1ns/1ps

module mem_decode (
	input  logic              clk,
	input  logic              rst_n,
	input  mem_pkg::ex_mem_t  ex_mem,
	input  logic              done,
	output mem_pkg::mem_cmd_t cache_cmd,
	output mem_pkg::mem_cmd_t mmio_cmd
);

	// set while an accepted access is in flight
	logic busy;
	logic accept;
	logic is_mmio;
	logic cache_vld;
	logic mmio_vld;

	// captured request, shared by both paths
	mem_pkg::word_t cmd_addr;
	mem_pkg::word_t cmd_wdata;
	logic cmd_wr;

	// a held request is taken only once
	assign accept = ex_mem.mem_en && !busy;
	assign is_mmio = (ex_mem.alu_out & mem_pkg::mmio_mask) == mem_pkg::mmio_base;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cache_vld <= 1'b0;
			mmio_vld <= 1'b0;
		end else begin
			// single cycle pulse on the selected path
			cache_vld <= accept && !is_mmio;
			mmio_vld <= accept && is_mmio;
			if (accept)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_addr <= ex_mem.alu_out;
			cmd_wdata <= ex_mem.reg_2;
			cmd_wr <= ex_mem.mem_wrt;
		end
	end

	assign cache_cmd = '{valid: cache_vld, addr: cmd_addr, wdata: cmd_wdata, wr: cmd_wr};
	assign mmio_cmd = '{valid: mmio_vld, addr: cmd_addr, wdata: cmd_wdata, wr: cmd_wr};

	// one path per access
	a_one_path: assert property (@(posedge clk) disable iff (!rst_n)
		!(cache_cmd.valid && mmio_cmd.valid));

	// completion only for an access this block accepted
	a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> busy);

endmodule

// ==== mem_pkg.sv ====
package mem_pkg;

	// cache geometry
	// one line matches the host data width
	localparam int line_bits = 512;
	localparam int word_bits = 32;
	localparam int num_lines = 8;
	localparam int index_bits = 3;
	localparam int offset_bits = 6;
	localparam int tag_bits = 23;
	localparam int words_per_line = line_bits / word_bits;
	// word select is addr[5:2]
	localparam int word_sel_bits = offset_bits - 2;

	// address map
	localparam logic [word_bits-1:0] fpu_start_addr = 32'h1000_0000;
	// uncached region, addr[31:28] == 4'h1
	localparam logic [word_bits-1:0] mmio_base = 32'h1000_0000;
	localparam logic [word_bits-1:0] mmio_mask = 32'hf000_0000;

	typedef logic [word_bits-1:0] word_t;

	// memory controller opcodes
	typedef enum logic [1:0] {
		host_idle  = 2'b00,
		host_read  = 2'b01,
		host_write = 2'b10
	} host_op_t;

	// execute stage outputs, held until done
	typedef struct packed {
		word_t alu_out;
		word_t reg_2;
		logic  mem_wrt;
		logic  mem_en;
	} ex_mem_t;

	// one accepted access
	typedef struct packed {
		logic  valid;
		word_t addr;
		word_t wdata;
		logic  wr;
	} mem_cmd_t;

	// one completion
	// load marks completions that update the load result
	typedef struct packed {
		logic  valid;
		word_t rdata;
		logic  start;
		logic  load;
	} mem_rsp_t;

	// to the memory controller, addr is line aligned
	typedef struct packed {
		host_op_t               op;
		word_t                  addr;
		logic [line_bits-1:0]   data;
	} host_req_t;

	// from the memory controller
	typedef struct packed {
		logic [line_bits-1:0] data;
		logic                 tx_done;
		logic                 rd_valid;
	} host_rsp_t;

endpackage

// ==== mem_result.sv ====
`timescale 1ns/1ps

module mem_result (
	input  logic                          clk,
	input  logic                          rst_n,
	input  mem_pkg::mem_rsp_t             cache_rsp,
	input  mem_pkg::mem_cmd_t             mmio_cmd,
	output logic                          done,
	output logic [mem_pkg::word_bits-1:0] mem_data,
	output logic                          start_fpu
);

	// mmio completion, one stage behind the command
	logic mmio_vld;
	logic mmio_load;
	logic mmio_start;
	mem_pkg::mem_rsp_t mmio_rsp;

	// uncached loads read as zero
	assign mmio_rsp = '{valid: mmio_vld, rdata: '0, start: mmio_start, load: mmio_load};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mmio_vld <= 1'b0;
			done <= 1'b0;
			start_fpu <= 1'b0;
			mem_data <= '0;
		end else begin
			mmio_vld <= mmio_cmd.valid;
			mmio_load <= !mmio_cmd.wr;
			mmio_start <= mmio_cmd.wr && (mmio_cmd.addr == mem_pkg::fpu_start_addr);
			// either path finishes the access
			done <= cache_rsp.valid || mmio_rsp.valid;
			start_fpu <= mmio_rsp.valid && mmio_rsp.start;
			// stores leave the last load result alone
			if (cache_rsp.valid && cache_rsp.load)
				mem_data <= cache_rsp.rdata;
			else if (mmio_rsp.valid && mmio_rsp.load)
				mem_data <= mmio_rsp.rdata;
		end
	end

	// cache and mmio never finish in the same window
	a_one_source: assert property (@(posedge clk) disable iff (!rst_n)
		!(cache_rsp.valid && mmio_cmd.valid));

endmodule

// ==== memory.sv ====
`timescale 1ns/1ps

module memory (
	input  logic                          clk,
	input  logic                          rst_n,
	// execute stage
	input  mem_pkg::ex_mem_t              ex_mem,
	output logic [mem_pkg::word_bits-1:0] mem_data,
	output logic                          done,
	// kicks off the FPU
	output logic                          start_fpu,
	// memory controller
	output mem_pkg::host_req_t            host_req,
	input  mem_pkg::host_rsp_t            host_rsp
);

	mem_pkg::mem_cmd_t cache_cmd;
	mem_pkg::mem_cmd_t mmio_cmd;
	mem_pkg::mem_rsp_t cache_rsp;

	// address classify and accept
	mem_decode u_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.ex_mem    (ex_mem),
		.done      (done),
		.cache_cmd (cache_cmd),
		.mmio_cmd  (mmio_cmd)
	);

	// cacheable path
	dcache u_dcache (
		.clk      (clk),
		.rst_n    (rst_n),
		.cmd      (cache_cmd),
		.rsp      (cache_rsp),
		.host_req (host_req),
		.host_rsp (host_rsp)
	);

	// completion merge
	mem_result u_result (
		.clk       (clk),
		.rst_n     (rst_n),
		.cache_rsp (cache_rsp),
		.mmio_cmd  (mmio_cmd),
		.done      (done),
		.mem_data  (mem_data),
		.start_fpu (start_fpu)
	);

endmodule

// ==== tb.f ====
mem_pkg.sv
mem_decode.sv
dcache.sv
mem_result.sv
memory.sv
tb_memory.sv

// ==== tb_memory.sv ====
`timescale 1ns/1ps

module tb_memory;

	// cacheable window of four times the cache size
	localparam mem_pkg::word_t win_base = 32'h0000_2000;
	localparam mem_pkg::word_t win_end = 32'h0000_2800;
	localparam int num_access = 400;
	localparam int done_timeout = 100;

	logic clk;
	logic rst_n;
	mem_pkg::ex_mem_t ex_mem;
	mem_pkg::word_t mem_data;
	logic done;
	logic start_fpu;
	mem_pkg::host_req_t host_req;
	mem_pkg::host_rsp_t host_rsp;

	// reference words indexed by addr[10:2]
	mem_pkg::word_t model_mem [512];
	// controller backing lines indexed by addr[10:6]
	logic [mem_pkg::line_bits-1:0] backing [32];
	// expected tags to tell a hit from a miss
	mem_pkg::word_t tag_line [mem_pkg::num_lines];
	logic [mem_pkg::num_lines-1:0] tag_valid;

	memory UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.ex_mem    (ex_mem),
		.mem_data  (mem_data),
		.done      (done),
		.start_fpu (start_fpu),
		.host_req  (host_req),
		.host_rsp  (host_rsp)
	);

	always #50 clk = ~clk;

	// preload pattern over the whole address
	function automatic mem_pkg::word_t fill_word(mem_pkg::word_t addr);
		return (addr * 32'h9e37_79b1) ^ 32'h3c6e_f372;
	endfunction

	// word 0 sits in the low bits of the line
	function automatic logic [mem_pkg::line_bits-1:0] model_line(logic [4:0] li);
		logic [mem_pkg::line_bits-1:0] line;
		for (int k = 0; k < mem_pkg::words_per_line; k++)
			line[k*mem_pkg::word_bits +: mem_pkg::word_bits] = model_mem[{li, k[3:0]}];
		return line;
	endfunction

	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_word(string name, mem_pkg::word_t got, mem_pkg::word_t exp);
		if (got !== exp)
			report_failure($sformatf("** Error %s got 0x%08h expected 0x%08h", name, got, exp));
	endtask

	task automatic check_pulse(string name, logic got, logic exp);
		if (got !== exp)
			report_failure($sformatf("** Error %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic check_writeback(mem_pkg::host_req_t got, logic [mem_pkg::line_bits-1:0] exp);
		if (got.data !== exp)
			report_failure($sformatf("** Error host_req.data at 0x%08h got 0x%0h expected 0x%0h",
				got.addr, got.data, exp));
	endtask

	task automatic check_held(mem_pkg::host_req_t got, mem_pkg::host_req_t exp);
		if (got !== exp)
			report_failure($sformatf("** Error host_req op 0x%0h addr 0x%08h expected 0x%0h 0x%08h",
				got.op, got.addr, exp.op, exp.addr));
	endtask

	task automatic check_idle();
		check_pulse("done", done, 1'b0);
		check_pulse("start_fpu", start_fpu, 1'b0);
		check_pulse("host_req.op active", host_req.op != mem_pkg::host_idle, 1'b0);
		check_word("mem_data", mem_data, '0);
	endtask

	// answer one host request after 0 to 7 cycles
	task automatic serve_host();
		mem_pkg::host_req_t held;
		int unsigned delay;
		logic [4:0] li;
		held = host_req;
		delay = $urandom_range(7);
		li = held.addr[10:6];
		if (held.addr < win_base || held.addr >= win_end || held.addr[5:0] != '0)
			report_failure($sformatf("host request to 0x%08h is not a line of the window", held.addr));
		// victim line must match the model right now
		if (held.op == mem_pkg::host_write)
			check_writeback(held, model_line(li));
		repeat (delay) begin
			@(posedge clk);
			check_held(host_req, held);
		end
		if (held.op == mem_pkg::host_write) begin
			backing[li] = held.data;
			host_rsp.tx_done <= 1'b1;
		end else begin
			host_rsp.data <= backing[li];
			host_rsp.rd_valid <= 1'b1;
		end
		@(posedge clk);
		// still held on the edge that takes the response
		check_held(host_req, held);
		host_rsp.tx_done <= 1'b0;
		host_rsp.rd_valid <= 1'b0;
	endtask

	// memory controller stand-in
	initial begin
		host_rsp <= '0;
		forever begin
			@(posedge clk);
			if (rst_n && host_req.op != mem_pkg::host_idle)
				serve_host();
		end
	end

	initial begin
		mem_pkg::word_t addr;
		mem_pkg::word_t wdata;
		mem_pkg::word_t last_load;
		mem_pkg::word_t last_store;
		logic wr;
		logic cacheable;
		logic hit;
		logic exp_start;
		logic [mem_pkg::index_bits-1:0] idx;
		int unsigned pick;
		int unsigned cycles;
		void'($urandom(32'hbc35));
		clk = 1'b0;
		rst_n <= 1'b0;
		ex_mem <= '0;
		last_load = '0;
		last_store = win_base;
		tag_valid = '0;
		for (mem_pkg::word_t a = win_base; a < win_end; a += 4)
			model_mem[a[10:2]] = fill_word(a);
		for (mem_pkg::word_t a = win_base; a < win_end; a += 64)
			backing[a[10:6]] = model_line(a[10:6]);

		// 16 reset cycles with outputs known from the second edge
		@(posedge clk);
		repeat (15) begin
			@(posedge clk);
			check_idle();
		end
		rst_n <= 1'b1;
		@(posedge clk);
		check_idle();

		for (int n = 0; n < num_access; n++) begin
			pick = $urandom_range(99);
			wr = 1'($urandom_range(1));
			wdata = $urandom;
			// reload of a stored word then cacheable then fpu start then other mmio
			if (pick < 15) begin
				addr = last_store;
				wr = 1'b0;
			end else if (pick < 80)
				addr = win_base | ($urandom_range(511) << 2);
			else if (pick < 90)
				addr = mem_pkg::fpu_start_addr;
			else
				addr = mem_pkg::mmio_base | ($urandom & 32'h0fff_fffc);
			cacheable = (addr & mem_pkg::mmio_mask) != mem_pkg::mmio_base;
			exp_start = wr && addr == mem_pkg::fpu_start_addr;
			idx = addr[8:6];
			hit = cacheable && tag_valid[idx] && tag_line[idx] == (addr & 32'hffff_ffc0);

			@(posedge clk);
			// previous done and start_fpu were single pulses
			check_pulse("done", done, 1'b0);
			check_pulse("start_fpu", start_fpu, 1'b0);
			ex_mem <= '{alu_out: addr, reg_2: wdata, mem_wrt: wr, mem_en: 1'b1};
			cycles = 0;
			do begin
				@(posedge clk);
				cycles++;
				check_pulse("start_fpu", start_fpu, done && exp_start);
				if (cycles > done_timeout)
					report_failure($sformatf("no done within %0d cycles for 0x%08h",
						done_timeout, addr));
			end while (!done);
			ex_mem <= '0;

			// hit and mmio take a fixed 4 edges while a miss needs the host
			if (!cacheable || hit) begin
				if (cycles != 4)
					report_failure($sformatf("done after %0d cycles on a hit or mmio, not 4", cycles));
			end else if (cycles < 8) begin
				report_failure($sformatf("done after %0d cycles on a miss, too early", cycles));
			end

			if (cacheable) begin
				tag_valid[idx] = 1'b1;
				tag_line[idx] = addr & 32'hffff_ffc0;
				if (wr) begin
					model_mem[addr[10:2]] = wdata;
					last_store = addr;
				end else begin
					last_load = model_mem[addr[10:2]];
				end
			end else if (!wr) begin
				last_load = '0;
			end
			// stores leave the last load in place
			check_word("mem_data", mem_data, last_load);
		end

		@(posedge clk);
		check_pulse("done", done, 1'b0);
		check_pulse("start_fpu", start_fpu, 1'b0);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule
